/* src/loader_pkg.sv */
// download header layout, region codes and the CPU byte scramble
// header is 64 bytes, region starts are little-endian in kilobytes of the body
// decrypt masks assume the byte arrives in its stored (scrambled) form

package loader_pkg;

    localparam int DL_AW = 25;          // byte address, up to 32 MB

    localparam int HEADER_BYTES = 64;
    localparam int START_BYTES  = 8;    // four 16-bit region starts
    localparam int CFG_FIRST    = 8;
    localparam int CFG_LAST     = 39;   // 40 to 63 reserved

    typedef enum logic [2:0] {
        CPU,
        SND,
        PCM,
        GFX,
        AUX,
        NONE
    } region_t;

    // XORed into the result when the matching input bit is 1
    localparam logic [7:0] DECRYPT_MASKS [0:7] = '{
        8'h04, 8'h21, 8'h01, 8'h00, 8'h40, 8'h06, 8'h08, 8'h00
    };

    // only bits 3 and 7 add a term when they are 0
    localparam logic [7:0] DECRYPT_FLIP [0:7] = '{
        8'h00, 8'h00, 8'h00, 8'h50, 8'h00, 8'h00, 8'h00, 8'h88
    };

endpackage

/* src/sdram_pkg.sv */
// SDRAM write side widths, bank codes and byte masks
// the mask is active low, a zero bit enables that byte lane

package sdram_pkg;

    localparam int SD_AW = 22;          // 16-bit word address
    localparam int SD_DW = 16;

    typedef logic [1:0] bank_t;

    localparam bank_t BANK_CLEAR = 2'd0;    // only the clear sweep uses it
    localparam bank_t BANK_SND   = 2'd1;    // sound and PCM share it
    localparam bank_t BANK_GFX   = 2'd2;
    localparam bank_t BANK_CPU   = 2'd3;

    localparam logic [1:0] MASK_LO   = 2'b10;   // even byte address
    localparam logic [1:0] MASK_HI   = 2'b01;   // odd byte address
    localparam logic [1:0] MASK_BOTH = 2'b00;

endpackage

/* src/header_capture.sv */
// first stage of the download router
// start bytes must arrive in order 0..7, they are shifted in, not indexed
// the flag byte at CFG_BYTE must sit inside the config range 8..39
`timescale 1ns/100ps

module header_capture
    import loader_pkg::*;
#(
    parameter int CFG_BYTE = 39
)(
    input  logic             clk,
    input  logic             reset,
    input  logic             dl_active,
    input  logic             dl_wr,
    input  logic [DL_AW-1:0] dl_addr,
    input  logic [7:0]       dl_data,
    output logic             cfg_we,
    output logic [5:0]       cfg_addr,
    output logic [7:0]       cfg_data,
    output logic             body_valid,
    output logic [DL_AW-1:0] body_addr,
    output logic [7:0]       body_data,
    output logic [15:0]      snd_start,
    output logic [15:0]      pcm_start,
    output logic [15:0]      gfx_start,
    output logic [15:0]      aux_start,
    output logic             decrypt_en,
    output logic             decrypt_phase,
    output logic             active_out
);

    logic [8*START_BYTES-1:0] starts;
    logic is_start, is_cfg, is_body, is_flag;

    assign is_start = dl_addr < DL_AW'(START_BYTES);
    assign is_cfg   = dl_addr >= DL_AW'(CFG_FIRST) && dl_addr <= DL_AW'(CFG_LAST);
    assign is_body  = dl_addr >= DL_AW'(HEADER_BYTES);
    assign is_flag  = dl_addr == DL_AW'(CFG_BYTE);

    assign snd_start = starts[15:0];
    assign pcm_start = starts[31:16];
    assign gfx_start = starts[47:32];
    assign aux_start = starts[63:48];

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_we        <= 1'b0;
            body_valid    <= 1'b0;
            decrypt_en    <= 1'b0;
            decrypt_phase <= 1'b0;
            active_out    <= 1'b0;
        end else begin
            cfg_we     <= dl_wr && is_cfg;
            body_valid <= dl_wr && is_body;
            // high from the first strobe until the download ends
            active_out <= dl_active && (dl_wr || active_out);
            if (!dl_active) begin
                decrypt_en <= 1'b0;
            end else if (dl_wr && is_cfg && is_flag) begin
                decrypt_en    <= dl_data[7];
                decrypt_phase <= dl_data[6];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dl_wr) begin
            cfg_addr  <= dl_addr[5:0];
            cfg_data  <= dl_data;
            body_addr <= dl_addr - DL_AW'(HEADER_BYTES);   // header excluded
            body_data <= dl_data;
            if (is_start) starts <= {dl_data, starts[8*START_BYTES-1:8]};
        end
    end

endmodule

/* src/region_mapper.sv */
// second stage, classifies body bytes and builds the SDRAM byte write
// regions are assumed in ascending order: CPU, sound, PCM, graphics, aux
// only the low 15 bits of each start are used (32 MB body at most)
// aux bytes bypass the scramble and go to the internal ROM port
`timescale 1ns/100ps

module region_mapper
    import loader_pkg::*;
    import sdram_pkg::*;
#(
    parameter logic [SD_AW-1:0] CPU_OFFSET = '0,
    parameter logic [SD_AW-1:0] SND_OFFSET = '0,
    parameter logic [SD_AW-1:0] PCM_OFFSET = '0,
    parameter logic [SD_AW-1:0] GFX_OFFSET = '0
)(
    input  logic             clk,
    input  logic             reset,
    input  logic             body_valid,
    input  logic [DL_AW-1:0] body_addr,
    input  logic [7:0]       body_data,
    input  logic [15:0]      snd_start,
    input  logic [15:0]      pcm_start,
    input  logic [15:0]      gfx_start,
    input  logic [15:0]      aux_start,
    input  logic             decrypt_en,
    input  logic             decrypt_phase,
    output logic             wr_valid,
    output logic [SD_AW-1:0] wr_addr,
    output logic [SD_DW-1:0] wr_data,
    output logic [1:0]       wr_mask,
    output bank_t            wr_bank,
    output logic             aux_we,
    output logic [12:0]      aux_addr,
    output logic [7:0]       aux_data
);

    logic [15:0]      kb;           // kilobyte index inside the body
    region_t          region;
    logic [DL_AW-1:0] base;
    logic [DL_AW-1:0] rel;
    logic [SD_AW-1:0] offset;
    bank_t            bank;
    logic             scramble_on;
    logic [7:0]       byte_out;

    function automatic logic [7:0] descramble(input logic [7:0] d);
        logic [7:0] r;
        int i;
        r = '0;
        for (i = 0; i < 8; i++) begin
            r = r ^ (d[i] ? DECRYPT_MASKS[i] : DECRYPT_FLIP[i]);
        end
        return r;
    endfunction

    always_comb begin
        kb     = {1'b0, body_addr[DL_AW-1:10]};
        base   = '0;
        offset = CPU_OFFSET;
        bank   = BANK_CPU;
        if (kb < snd_start) begin
            region = CPU;
        end else if (kb < pcm_start) begin
            region = SND;
            base   = {snd_start[DL_AW-11:0], 10'd0};
            offset = SND_OFFSET;
            bank   = BANK_SND;
        end else if (kb < gfx_start) begin
            region = PCM;
            base   = {pcm_start[DL_AW-11:0], 10'd0};
            offset = PCM_OFFSET;
            bank   = BANK_SND;
        end else if (kb < aux_start) begin
            region = GFX;
            base   = {gfx_start[DL_AW-11:0], 10'd0};
            offset = GFX_OFFSET;
            bank   = BANK_GFX;
        end else begin
            region = AUX;
        end
    end

    assign rel = body_addr - base;

    // upper CPU half, one byte phase only
    assign scramble_on = region == CPU && body_addr[19] && decrypt_en
                         && (body_addr[0] ^ decrypt_phase);
    assign byte_out = scramble_on ? descramble(body_data) : body_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_valid <= 1'b0;
            aux_we   <= 1'b0;
        end else begin
            wr_valid <= body_valid && region inside {CPU, SND, PCM, GFX};
            aux_we   <= body_valid && region == AUX;
        end
    end

    always_ff @(posedge clk) begin
        if (body_valid) begin
            wr_addr  <= rel[SD_AW:1] + offset;     // byte to word address
            wr_data  <= {2{byte_out}};
            wr_mask  <= body_addr[0] ? MASK_HI : MASK_LO;
            wr_bank  <= bank;
            aux_addr <= body_addr[12:0];
            aux_data <= body_data;
        end
    end

endmodule

/* src/sdram_writer.sv */
// third stage, write queue, credit counter and the RAM clear sweep
// the SDRAM side returns one sd_credit pulse per accepted write
// the queue relies on dl_hold; two bytes may still land after it rises
// the sweep spends credits like any other write
`timescale 1ns/100ps

module sdram_writer
    import sdram_pkg::*;
#(
    parameter int CREDITS     = 4,
    parameter int QUEUE_DEPTH = 4,
    parameter int CLEAR_AW    = SD_AW
)(
    input  logic             clk,
    input  logic             reset,
    input  logic             active,
    input  logic             wr_valid,
    input  logic [SD_AW-1:0] wr_addr,
    input  logic [SD_DW-1:0] wr_data,
    input  logic [1:0]       wr_mask,
    input  bank_t            wr_bank,
    input  logic             sd_credit,
    output logic             sd_we,
    output logic [SD_AW-1:0] sd_addr,
    output logic [SD_DW-1:0] sd_data,
    output logic [1:0]       sd_mask,
    output bank_t            sd_bank,
    output logic             dl_hold,
    output logic             busy
);

    localparam int PW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CW = $clog2(QUEUE_DEPTH + 1);
    localparam int KW = $clog2(CREDITS + 1);

    logic [SD_AW-1:0]    q_addr [QUEUE_DEPTH];
    logic [SD_DW-1:0]    q_data [QUEUE_DEPTH];
    logic [1:0]          q_mask [QUEUE_DEPTH];
    bank_t               q_bank [QUEUE_DEPTH];
    logic [PW-1:0]       rd_ptr;
    logic [PW-1:0]       wr_ptr;
    logic [CW-1:0]       count;
    logic [KW-1:0]       credits;
    logic                active_d;
    logic                seen_wr;       // some SDRAM byte came in this download
    logic                end_pending;
    logic                sweep_on;
    logic                sweep_last;
    logic [CLEAR_AW-1:0] sweep_addr;
    logic can_issue, pop, bypass, push, sweep_issue, issue, fell;

    assign can_issue   = credits != '0;
    assign sweep_issue = sweep_on && can_issue;
    assign pop         = !sweep_on && can_issue && count != '0;
    assign bypass      = !sweep_on && can_issue && count == '0 && wr_valid;
    assign push        = wr_valid && !bypass;
    assign issue       = pop || bypass || sweep_issue;
    assign fell        = active_d && !active;
    assign dl_hold     = count >= CW'(QUEUE_DEPTH - 2);   // room for two in flight

    always_ff @(posedge clk) begin
        if (push) begin
            q_addr[wr_ptr] <= wr_addr;
            q_data[wr_ptr] <= wr_data;
            q_mask[wr_ptr] <= wr_mask;
            q_bank[wr_ptr] <= wr_bank;
        end
        if (sweep_issue) begin
            sd_addr <= SD_AW'(sweep_addr);
            sd_data <= '0;
            sd_mask <= MASK_BOTH;
            sd_bank <= BANK_CLEAR;
        end else if (pop) begin
            sd_addr <= q_addr[rd_ptr];
            sd_data <= q_data[rd_ptr];
            sd_mask <= q_mask[rd_ptr];
            sd_bank <= q_bank[rd_ptr];
        end else if (bypass) begin       // empty queue, straight out
            sd_addr <= wr_addr;
            sd_data <= wr_data;
            sd_mask <= wr_mask;
            sd_bank <= wr_bank;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr      <= '0;
            wr_ptr      <= '0;
            count       <= '0;
            credits     <= KW'(CREDITS);
            sd_we       <= 1'b0;
            active_d    <= 1'b0;
            seen_wr     <= 1'b0;
            end_pending <= 1'b0;
            sweep_on    <= 1'b0;
            sweep_last  <= 1'b0;
            sweep_addr  <= '0;
            busy        <= 1'b0;
        end else begin
            sd_we    <= issue;
            active_d <= active;
            credits  <= credits - KW'(issue) + KW'(sd_credit);
            count    <= count + CW'(push) - CW'(pop);
            if (push) wr_ptr <= (wr_ptr == PW'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop) rd_ptr <= (rd_ptr == PW'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (wr_valid) seen_wr <= 1'b1;
            if (active) busy <= 1'b1;
            if (sweep_last) begin       // last zero write is on the bus now
                sweep_last <= 1'b0;
                busy       <= 1'b0;
            end
            if (fell) begin
                if (seen_wr || wr_valid) end_pending <= 1'b1;
                else busy <= 1'b0;       // nothing went to SDRAM, no sweep
            end
            // wait for the queue to drain before clearing
            if (end_pending && count == '0 && !sweep_on) begin
                sweep_on    <= 1'b1;
                sweep_addr  <= '0;
                end_pending <= 1'b0;
                seen_wr     <= 1'b0;
            end
            if (sweep_issue) begin
                sweep_addr <= sweep_addr + 1'b1;
                if (&sweep_addr) begin
                    sweep_on   <= 1'b0;
                    sweep_last <= 1'b1;
                end
            end
        end
    end

endmodule

/* src/rom_loader_top.sv */
// ROM download router, header capture -> region mapper -> SDRAM writer
// the source must not strobe while dl_hold is high
// CLEAR_AW sets how many SDRAM words the end-of-download sweep zeroes
`timescale 1ns/100ps

module rom_loader_top
    import loader_pkg::*;
    import sdram_pkg::*;
#(
    parameter int               CFG_BYTE    = 39,
    parameter logic [SD_AW-1:0] CPU_OFFSET  = '0,
    parameter logic [SD_AW-1:0] SND_OFFSET  = '0,
    parameter logic [SD_AW-1:0] PCM_OFFSET  = '0,
    parameter logic [SD_AW-1:0] GFX_OFFSET  = '0,
    parameter int               CREDITS     = 4,
    parameter int               QUEUE_DEPTH = 4,
    parameter int               CLEAR_AW    = SD_AW
)(
    input  logic             clk,
    input  logic             reset,
    input  logic             dl_active,
    input  logic             dl_wr,
    input  logic [DL_AW-1:0] dl_addr,
    input  logic [7:0]       dl_data,
    input  logic             sd_credit,
    output logic             dl_hold,
    output logic             cfg_we,
    output logic [5:0]       cfg_addr,
    output logic [7:0]       cfg_data,
    output logic             sd_we,
    output logic [SD_AW-1:0] sd_addr,
    output logic [SD_DW-1:0] sd_data,
    output logic [1:0]       sd_mask,
    output bank_t            sd_bank,
    output logic             aux_we,
    output logic [12:0]      aux_addr,
    output logic [7:0]       aux_data,
    output logic             busy
);

    logic             body_valid;
    logic [DL_AW-1:0] body_addr;
    logic [7:0]       body_data;
    logic [15:0]      snd_start, pcm_start, gfx_start, aux_start;
    logic             decrypt_en, decrypt_phase;
    logic             active;       // download level, aligned with stage 1
    logic             wr_valid;
    logic [SD_AW-1:0] wr_addr;
    logic [SD_DW-1:0] wr_data;
    logic [1:0]       wr_mask;
    bank_t            wr_bank;

    header_capture #(
        .CFG_BYTE (CFG_BYTE)
    ) u_header (
        .clk           (clk),
        .reset         (reset),
        .dl_active     (dl_active),
        .dl_wr         (dl_wr),
        .dl_addr       (dl_addr),
        .dl_data       (dl_data),
        .cfg_we        (cfg_we),
        .cfg_addr      (cfg_addr),
        .cfg_data      (cfg_data),
        .body_valid    (body_valid),
        .body_addr     (body_addr),
        .body_data     (body_data),
        .snd_start     (snd_start),
        .pcm_start     (pcm_start),
        .gfx_start     (gfx_start),
        .aux_start     (aux_start),
        .decrypt_en    (decrypt_en),
        .decrypt_phase (decrypt_phase),
        .active_out    (active)
    );

    region_mapper #(
        .CPU_OFFSET (CPU_OFFSET),
        .SND_OFFSET (SND_OFFSET),
        .PCM_OFFSET (PCM_OFFSET),
        .GFX_OFFSET (GFX_OFFSET)
    ) u_mapper (
        .clk           (clk),
        .reset         (reset),
        .body_valid    (body_valid),
        .body_addr     (body_addr),
        .body_data     (body_data),
        .snd_start     (snd_start),
        .pcm_start     (pcm_start),
        .gfx_start     (gfx_start),
        .aux_start     (aux_start),
        .decrypt_en    (decrypt_en),
        .decrypt_phase (decrypt_phase),
        .wr_valid      (wr_valid),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_mask       (wr_mask),
        .wr_bank       (wr_bank),
        .aux_we        (aux_we),
        .aux_addr      (aux_addr),
        .aux_data      (aux_data)
    );

    sdram_writer #(
        .CREDITS     (CREDITS),
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .CLEAR_AW    (CLEAR_AW)
    ) u_writer (
        .clk       (clk),
        .reset     (reset),
        .active    (active),
        .wr_valid  (wr_valid),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_mask   (wr_mask),
        .wr_bank   (wr_bank),
        .sd_credit (sd_credit),
        .sd_we     (sd_we),
        .sd_addr   (sd_addr),
        .sd_data   (sd_data),
        .sd_mask   (sd_mask),
        .sd_bank   (sd_bank),
        .dl_hold   (dl_hold),
        .busy      (busy)
    );

endmodule

/* dv/rom_loader_assertions.sv */
// credit and queue rules of the SDRAM writer, bound into every sdram_writer
// counters restart on reset, so checks only cover the current run
`timescale 1ns/100ps

module rom_loader_assertions #(
    parameter int CREDITS     = 4,
    parameter int QUEUE_DEPTH = 4
)(
    input logic                               clk,
    input logic                               reset,
    input logic                               sd_we,
    input logic                               sd_credit,
    input logic [$clog2(CREDITS+1)-1:0]       credits,
    input logic [$clog2(QUEUE_DEPTH+1)-1:0]   count
);

    int issued;
    int returned;

    always_ff @(posedge clk) begin
        if (reset) begin
            issued   <= 0;
            returned <= 0;
        end else begin
            issued   <= issued + int'(sd_we);
            returned <= returned + int'(sd_credit);
        end
    end

    a_credit_max: assert property (@(posedge clk) disable iff (reset)
        int'(credits) <= CREDITS)
        else $error("credit count above its initial value");

    a_spend_limit: assert property (@(posedge clk) disable iff (reset)
        issued <= CREDITS + returned)
        else $error("more SDRAM writes than credits given");

    a_queue_max: assert property (@(posedge clk) disable iff (reset)
        int'(count) <= QUEUE_DEPTH)
        else $error("write queue overflow");

endmodule

bind sdram_writer rom_loader_assertions #(
    .CREDITS     (CREDITS),
    .QUEUE_DEPTH (QUEUE_DEPTH)
) u_assert (
    .clk       (clk),
    .reset     (reset),
    .sd_we     (sd_we),
    .sd_credit (sd_credit),
    .credits   (credits),
    .count     (count)
);

/* dv/rom_loader_checker.sv */
// compares config, SDRAM and aux writes with the expected lists, in order
// expected entries are loaded through exp_valid before the download starts
// SDRAM writes past the list must be the clear sweep, ascending from 0
`timescale 1ns/100ps

module rom_loader_checker
    import sdram_pkg::*;
#(
    parameter int CLEAR_AW = 5
)(
    input  logic             clk,
    input  logic             reset,
    input  logic             exp_valid,
    input  logic [1:0]       exp_kind,      // 1 cfg, 2 sdram, 3 aux
    input  logic [41:0]      exp_word,
    input  logic             cfg_we,
    input  logic [5:0]       cfg_addr,
    input  logic [7:0]       cfg_data,
    input  logic             sd_we,
    input  logic [SD_AW-1:0] sd_addr,
    input  logic [SD_DW-1:0] sd_data,
    input  logic [1:0]       sd_mask,
    input  bank_t            sd_bank,
    input  logic             aux_we,
    input  logic [12:0]      aux_addr,
    input  logic [7:0]       aux_data,
    output int               value_errs,
    output int               other_errs,
    output int               pending,
    output int               sweep_seen
);

    logic [13:0] cfg_q [$];
    logic [41:0] sd_q [$];
    logic [20:0] aux_q [$];
    logic [13:0] cfg_exp;
    logic [41:0] sd_exp;
    logic [20:0] aux_exp;

    always @(posedge clk) begin
        if (exp_valid) begin
            case (exp_kind)
                2'd1: cfg_q.push_back(exp_word[13:0]);
                2'd2: sd_q.push_back(exp_word);
                default: aux_q.push_back(exp_word[20:0]);
            endcase
        end
        if (reset) begin
            value_errs <= 0;
            other_errs <= 0;
            sweep_seen <= 0;
        end else begin
            if (cfg_we) begin
                if (cfg_q.size() == 0) begin
                    $display("unexpected config write at %0t", $time);
                    other_errs <= other_errs + 1;
                end else begin
                    cfg_exp = cfg_q.pop_front();
                    if (cfg_exp != {cfg_addr, cfg_data}) begin
                        $display("ERR %0t: cfg write %h/%h, expected %h/%h", $time,
                                 cfg_addr, cfg_data, cfg_exp[13:8], cfg_exp[7:0]);
                        value_errs <= value_errs + 1;
                    end
                end
            end
            if (sd_we) begin
                if (sd_q.size() != 0) sd_exp = sd_q.pop_front();
                else sd_exp = {BANK_CLEAR, MASK_BOTH, SD_AW'(sweep_seen), 16'h0000};
                if (sd_q.size() == 0 && sweep_seen >= 2**CLEAR_AW) begin
                    $display("extra SDRAM write after the clear sweep at %0t", $time);
                    other_errs <= other_errs + 1;
                end else if (sd_exp != {sd_bank, sd_mask, sd_addr, sd_data}) begin
                    $display("ERR %0t: sdram bank %h mask %b addr %h data %h, expected %h",
                             $time, sd_bank, sd_mask, sd_addr, sd_data, sd_exp);
                    value_errs <= value_errs + 1;
                end
                if (sd_exp[41:38] == 4'h0 && sd_q.size() == 0) sweep_seen <= sweep_seen + 1;
            end
            if (aux_we) begin
                if (aux_q.size() == 0) begin
                    $display("unexpected aux write at %0t", $time);
                    other_errs <= other_errs + 1;
                end else begin
                    aux_exp = aux_q.pop_front();
                    if (aux_exp != {aux_addr, aux_data}) begin
                        $display("ERR %0t: aux write %h/%h, expected %h/%h", $time,
                                 aux_addr, aux_data, aux_exp[20:8], aux_exp[7:0]);
                        value_errs <= value_errs + 1;
                    end
                end
            end
        end
        pending <= cfg_q.size() + sd_q.size() + aux_q.size();
    end

endmodule

/* dv/rom_loader_tb.sv */
// testbench for the ROM download router, stimulus and expectations come from the cases file
// the SDRAM side is a credit model only, each write returns a credit 0..3 cycles later
`timescale 1ns/100ps

module rom_loader_tb
    import loader_pkg::*, sdram_pkg::*;
;

    localparam int CLEAR_AW    = 5;
    localparam int HOLD_LIMIT  = 200;
    localparam int DRAIN_LIMIT = 2000;

    logic clk, reset, dl_active, dl_wr, sd_credit = 1'b0;
    logic [DL_AW-1:0] dl_addr;
    logic [7:0]       dl_data;
    logic dl_hold, cfg_we, sd_we, aux_we, busy;
    logic [5:0]       cfg_addr;
    logic [7:0]       cfg_data, aux_data;
    logic [SD_AW-1:0] sd_addr;
    logic [SD_DW-1:0] sd_data;
    logic [1:0]       sd_mask;
    bank_t            sd_bank;
    logic [12:0]      aux_addr;
    logic             exp_valid;
    logic [1:0]       exp_kind;
    logic [41:0]      exp_word;
    int value_errs, other_errs, pending, sweep_seen, tb_errs;
    logic [63:0] cases [0:255];
    int cyc = 0;
    int due_q [$];
    logic [31:0] lfsr = 32'h83ab40b8;

    rom_loader_top #(
        .SND_OFFSET (22'h100000),
        .PCM_OFFSET (22'h180000),
        .GFX_OFFSET (22'h200000),
        .CLEAR_AW   (CLEAR_AW)
    ) UUT (.*);

    rom_loader_checker #(.CLEAR_AW(CLEAR_AW)) chk (.*);

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // credit model, one return per cycle at most
    always @(posedge clk) begin
        logic [31:0] s1, s2;
        int due;
        cyc <= cyc + 1;
        if (sd_we) begin
            s1 = lfsr_step(lfsr);
            s2 = lfsr_step(s1);
            due = cyc + 1 + int'({s1[0], s2[0]});
            if (due_q.size() != 0 && due <= due_q[$]) due = due_q[$] + 1;
            due_q.push_back(due);
            lfsr <= s2;
        end
    end

    always @(negedge clk) begin
        if (due_q.size() != 0 && due_q[0] <= cyc) begin
            sd_credit = 1'b1;
            void'(due_q.pop_front());
        end else begin
            sd_credit = 1'b0;
        end
    end

    task automatic load_expect(input logic [1:0] kind, input logic [41:0] word);
        exp_valid = 1'b1;
        exp_kind  = kind;
        exp_word  = word;
        @(negedge clk);
    endtask

    task automatic send_byte(input logic [DL_AW-1:0] a, input logic [7:0] d);
        int n;
        n = 0;
        while (dl_hold && n < HOLD_LIMIT) begin
            dl_wr = 1'b0;
            @(negedge clk);
            n++;
        end
        if (dl_hold) begin
            $display("timeout: dl_hold stayed high at %0t", $time);
            tb_errs++;
        end
        dl_wr   = 1'b1;
        dl_addr = a;
        dl_data = d;
        @(negedge clk);
    endtask

    initial begin
        int p, n_stream, n_list, i, k, n;
        reset = 1'b1;
        dl_active = 1'b0;
        dl_wr = 1'b0;
        dl_addr = '0;
        dl_data = '0;
        exp_valid = 1'b0;
        exp_kind = '0;
        exp_word = '0;
        tb_errs = 0;
        $readmemh("dv/rom_loader_cases.txt", cases);
        repeat (5) @(negedge clk);
        reset = 1'b0;
        n_stream = int'(cases[0]);
        p = 1 + n_stream;
        for (k = 1; k <= 3; k++) begin          // cfg, sdram, aux lists
            n_list = int'(cases[p]);
            for (i = 1; i <= n_list; i++) begin
                if (k == 1) load_expect(2'd1, {28'd0, cases[p+i][13:0]});
                else if (k == 2) load_expect(2'd2, {cases[p+i][45:44], cases[p+i][41:40],
                                                    cases[p+i][37:16], cases[p+i][15:0]});
                else load_expect(2'd3, {21'd0, cases[p+i][20:0]});
            end
            p = p + 1 + n_list;
        end
        exp_valid = 1'b0;
        dl_active = 1'b1;
        @(negedge clk);
        for (i = 1; i <= n_stream; i++) send_byte(cases[i][32:8], cases[i][7:0]);
        dl_wr = 1'b0;
        n = 0;
        while (pending != 0 && n < DRAIN_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (pending != 0) begin
            $display("timeout: %0d expected writes never arrived", pending);
            tb_errs++;
        end
        if (!busy) begin
            $display("busy was low during the download");
            tb_errs++;
        end
        dl_active = 1'b0;
        n = 0;
        while (busy && n < DRAIN_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            $display("timeout: busy never fell after the download");
            tb_errs++;
        end
        if (sweep_seen != 2**CLEAR_AW) begin
            $display("clear sweep gave %0d writes instead of %0d", sweep_seen, 2**CLEAR_AW);
            tb_errs++;
        end
        $display("errors: value %0d, other %0d, testbench %0d",
                 value_errs, other_errs, tb_errs);
        if (value_errs + other_errs + tb_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* dv/rom_loader_cases.txt */
// counts, then stream {addr 8 hex, data 2 hex}, cfg {addr, data}, sdram
// {bank 1 hex, mask 1 hex, word addr 6 hex, data 4 hex}, aux {addr 4 hex, data 2 hex}
4C
0000000000 0000000103 0000000204 0000000303 0000000408 0000000503 000000060C 0000000703
0000000808 0000000909 0000000A0A 0000000B0B 0000000C0C 0000000D0D 0000000E0E 0000000F0F
0000001010 0000001111 0000001212 0000001313 0000001414 0000001515 0000001616 0000001717
0000001818 0000001919 0000001A1A 0000001B1B 0000001C1C 0000001D1D 0000001E1E 0000001F1F
0000002020 0000002121 0000002222 0000002323 0000002424 0000002525 0000002626 0000002780
00000028EE 00000029EE 0000002AEE 0000002BEE 0000002CEE 0000002DEE 0000002EEE 0000002FEE
00000030EE 00000031EE 00000032EE 00000033EE 00000034EE 00000035EE 00000036EE 00000037EE
00000038EE 00000039EE 0000003AEE 0000003BEE 0000003CEE 0000003DEE 0000003EEE 0000003FEE
000000505A 00000051A5 000800403C 000800413C 00080043FF 000C004511
000C104222 000C204733 000C204644 000C305255 000C305366 0000006077
20
0808 0909 0A0A 0B0B 0C0C 0D0D 0E0E 0F0F
1010 1111 1212 1313 1414 1515 1616 1717
1818 1919 1A1A 1B1B 1C1C 1D1D 1E1E 1F1F
2020 2121 2222 2323 2424 2525 2626 2780
0A
320000085A5A 31000008A5A5 320400003C3C 31040000CFCF 310400016A6A
111000021111 121800012222 212000033333 222000034444 320000107777
02
101255 101366

/* rom_loader.f */
src/loader_pkg.sv
src/sdram_pkg.sv
src/header_capture.sv
src/region_mapper.sv
src/sdram_writer.sv
src/rom_loader_top.sv
dv/rom_loader_assertions.sv
dv/rom_loader_checker.sv
dv/rom_loader_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the ROM loader testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f rom_loader.f --top-module rom_loader_tb \
    || { echo "build failed"; exit 1; }

./obj_dir/Vrom_loader_tb > sim.log 2>&1
cat sim.log

grep -q "Simulation failed" sim.log && { echo "run failed"; exit 1; }
grep -q "Simulation passed" sim.log || { echo "run did not finish"; exit 1; }
echo "run ok"
